//--- filelist.f
hw/pixelPkg.sv
hw/dotGen.sv
hw/pixelFifo.sv
hw/baseCtrl.sv
hw/captiveShizuhaBase.sv
verification/baseChecker.sv
verification/baseTb.sv

//--- hw/baseCtrl.sv
// Wishbone register slave for mode, colour and enable; sequences the generator on frame boundaries
`timescale 1ns/1ps
`default_nettype none

module baseCtrl (
    input  logic                baseClk,
    input  logic                rstN,

    // Wishbone classic slave
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  logic [1:0]          wbAdr,
    input  logic [31:0]         wbDatWr,
    output logic [31:0]         wbDatRd,
    output logic                wbAck,

    // Generator and FIFO status
    input  logic                frameEnd,
    input  logic                fifoEmpty,
    output logic                run,
    output pixelPkg::drawModeT  drawMode,
    output pixelPkg::rgbT       fillColor
);

    pixelPkg::ctrlStateT state;
    pixelPkg::ctrlStateT nextState;
    logic                enableReg;
    logic                busy;
    logic                wrEn;
    logic                ctrlWr;

    //------------------------------------------------------------
    // Bus decode
    //------------------------------------------------------------
    // One-cycle ack, never back to back
    always_ff @(posedge baseClk)
    begin
        if (!rstN)
            wbAck <= 1'b0;
        else
            wbAck <= wbCyc && wbStb && !wbAck;
    end

    // Master holds address and data through the ack cycle
    assign wrEn   = wbAck && wbWe;
    assign ctrlWr = wrEn && (wbAdr == pixelPkg::REG_CTRL);
    assign busy   = (state != pixelPkg::IDLE);
    assign run    = busy;

    // Registers
    always_ff @(posedge baseClk)
    begin
        if (!rstN)
        begin
            enableReg <= 1'b0;
            drawMode  <= pixelPkg::FILL;
            fillColor <= '0;
        end
        else
        begin
            if (ctrlWr)
                enableReg <= wbDatWr[0];
            // Mode and colour frozen while generating
            if (wrEn && !busy && wbAdr == pixelPkg::REG_MODE)
                drawMode <= pixelPkg::drawModeT'(wbDatWr[1:0]);
            if (wrEn && !busy && wbAdr == pixelPkg::REG_COLOR)
                fillColor <= wbDatWr[23:0];
        end
    end

    // Readback, valid only during ack
    always_comb
    begin
        wbDatRd = '0;
        if (wbAck && !wbWe)
        begin
            case (wbAdr)
                pixelPkg::REG_CTRL:   wbDatRd[0]    = enableReg;
                pixelPkg::REG_MODE:   wbDatRd[1:0]  = drawMode;
                pixelPkg::REG_COLOR:  wbDatRd[23:0] = fillColor;
                default:              wbDatRd[1:0]  = {fifoEmpty, busy};
            endcase
        end
    end

    //------------------------------------------------------------
    // Run/stop FSM
    //------------------------------------------------------------
    always_comb
    begin
        nextState = state;
        case (state)
            pixelPkg::IDLE:
                if (ctrlWr && wbDatWr[0])
                    nextState = pixelPkg::RUN;
            pixelPkg::RUN:
                if (ctrlWr && !wbDatWr[0])
                    nextState = pixelPkg::STOPPING;
            // Finish the frame in progress
            pixelPkg::STOPPING:
                if (frameEnd)
                    nextState = pixelPkg::IDLE;
            default:
                nextState = pixelPkg::IDLE;
        endcase
    end

    always_ff @(posedge baseClk)
    begin
        if (!rstN)
            state <= pixelPkg::IDLE;
        else
            state <= nextState;
    end

    // Bus handshake and frame boundary checks
    assert property (@(posedge baseClk) disable iff (!rstN) wbAck |=> !wbAck);
    assert property (@(posedge baseClk) disable iff (!rstN) wbAck |-> wbStb);
    assert property (@(posedge baseClk) disable iff (!rstN)
        (state == pixelPkg::STOPPING) ##1 (state != pixelPkg::STOPPING) |-> $past(frameEnd));

endmodule

`default_nettype wire

//--- hw/captiveShizuhaBase.sv
// Top of the base pixel path; wires register control, dot generator and pixel FIFO together
`timescale 1ns/1ps
`default_nettype none

module captiveShizuhaBase #(
    parameter int pHdisplay  = 640,
    parameter int pVdisplay  = 480,
    parameter int pBuffDepth = 1024
)(
    input  logic           baseClk,
    input  logic           pixelClk,
    input  logic           rstN,

    // Wishbone classic slave, base clock
    input  logic           wbCyc,
    input  logic           wbStb,
    input  logic           wbWe,
    input  logic [1:0]     wbAdr,
    input  logic [31:0]    wbDatWr,
    output logic [31:0]    wbDatRd,
    output logic           wbAck,

    // Pixel clock side
    input  logic           vde,
    output pixelPkg::rgbT  vRgb,
    output logic           pixelValid
);

    //------------------------------------------------------------
    // Internal nets
    //------------------------------------------------------------
    logic                 run;
    pixelPkg::drawModeT   drawMode;
    pixelPkg::rgbT        fillColor;
    logic                 frameEnd;
    pixelPkg::rgbT        pixel;
    logic                 pixelWe;
    logic                 full;
    logic                 fifoEmpty;

    //------------------------------------------------------------
    // Register slave and run/stop sequencing
    //------------------------------------------------------------
    baseCtrl u_baseCtrl (
        .baseClk   (baseClk),   .rstN      (rstN),
        .wbCyc     (wbCyc),     .wbStb     (wbStb),
        .wbWe      (wbWe),      .wbAdr     (wbAdr),
        .wbDatWr   (wbDatWr),   .wbDatRd   (wbDatRd),
        .wbAck     (wbAck),     .frameEnd  (frameEnd),
        .fifoEmpty (fifoEmpty), .run       (run),
        .drawMode  (drawMode),  .fillColor (fillColor)
    );

    // Pattern source, base clock
    dotGen #(
        .pHdisplay (pHdisplay),
        .pVdisplay (pVdisplay)
    ) u_dotGen (
        .baseClk   (baseClk),   .rstN      (rstN),
        .run       (run),       .full      (full),
        .drawMode  (drawMode),  .fillColor (fillColor),
        .pixel     (pixel),     .pixelWe   (pixelWe),
        .frameEnd  (frameEnd)
    );

    // Base clock to pixel clock crossing
    pixelFifo #(
        .pBuffDepth (pBuffDepth)
    ) u_pixelFifo (
        .baseClk   (baseClk),   .pixelClk   (pixelClk),
        .rstN      (rstN),      .pixel      (pixel),
        .pixelWe   (pixelWe),   .full       (full),
        .fifoEmpty (fifoEmpty), .vde        (vde),
        .vRgb      (vRgb),      .pixelValid (pixelValid)
    );

endmodule

`default_nettype wire

//--- hw/dotGen.sv
// Raster dot generator; steps position and frame counters and forms one pixel per enabled cycle
`timescale 1ns/1ps
`default_nettype none

module dotGen #(
    parameter int pHdisplay = 640,
    parameter int pVdisplay = 480
)(
    input  logic                baseClk,
    input  logic                rstN,
    input  logic                run,
    input  logic                full,
    input  pixelPkg::drawModeT  drawMode,
    input  pixelPkg::rgbT       fillColor,
    output pixelPkg::rgbT       pixel,
    output logic                pixelWe,
    output logic                frameEnd
);

    localparam int XW = (pHdisplay > 1) ? $clog2(pHdisplay) : 1;
    localparam int YW = (pVdisplay > 1) ? $clog2(pVdisplay) : 1;

    logic [XW-1:0] xCnt;
    logic [YW-1:0] yCnt;
    logic [7:0]    frameCnt;
    logic          lastX;
    logic          lastY;
    logic [15:0]   xExt;
    logic [15:0]   yExt;
    logic [31:0]   barProd;
    logic [2:0]    barIdx;

    //------------------------------------------------------------
    // Raster counters
    //------------------------------------------------------------
    // Advance only when the FIFO has room
    assign pixelWe  = run && !full;
    assign lastX    = (xCnt == XW'(pHdisplay - 1));
    assign lastY    = (yCnt == YW'(pVdisplay - 1));
    assign frameEnd = pixelWe && lastX && lastY;

    always_ff @(posedge baseClk)
    begin
        if (!rstN || !run)
        begin
            xCnt     <= '0;
            yCnt     <= '0;
            frameCnt <= '0;
        end
        else if (pixelWe)
        begin
            if (lastX)
            begin
                xCnt <= '0;
                if (lastY)
                begin
                    yCnt     <= '0;
                    frameCnt <= frameCnt + 8'd1;
                end
                else
                    yCnt <= yCnt + 1'b1;
            end
            else
                xCnt <= xCnt + 1'b1;
        end
    end

    //------------------------------------------------------------
    // Pattern select
    //------------------------------------------------------------
    assign xExt    = 16'(xCnt);
    assign yExt    = 16'(yCnt);
    // Column to bar index, eight equal bands
    assign barProd = (32'(xCnt) * 32'd8) / pHdisplay;
    assign barIdx  = barProd[2:0];

    always_comb
    begin
        case (drawMode)
            pixelPkg::FILL:     pixel = fillColor;
            pixelPkg::BARS:     pixel = pixelPkg::BAR_COLORS[barIdx];
            pixelPkg::GRADIENT: pixel = {xExt[7:0], yExt[7:0], frameCnt};
            default:            pixel = '0;
        endcase
    end

    // Position stays on screen
    assert property (@(posedge baseClk) disable iff (!rstN)
        (32'(xCnt) < pHdisplay) && (32'(yCnt) < pVdisplay));

endmodule

`default_nettype wire

//--- hw/pixelFifo.sv
// Dual-clock pixel FIFO from the base clock to the pixel clock, Gray pointers, registered read port
`timescale 1ns/1ps
`default_nettype none

module pixelFifo #(
    parameter int pBuffDepth = 1024
)(
    input  logic           baseClk,
    input  logic           pixelClk,
    input  logic           rstN,

    // Write side, base clock
    input  pixelPkg::rgbT  pixel,
    input  logic           pixelWe,
    output logic           full,
    output logic           fifoEmpty,

    // Read side, pixel clock
    input  logic           vde,
    output pixelPkg::rgbT  vRgb,
    output logic           pixelValid
);

    localparam int AW = $clog2(pBuffDepth);

    pixelPkg::rgbT mem [pBuffDepth];

    // Write domain pointers
    logic [AW:0] wrBin;
    logic [AW:0] wrGray;
    logic [AW:0] wrBinNext;
    logic [AW:0] rdGraySync1;
    logic [AW:0] rdGraySync2;

    // Read domain pointers
    logic [AW:0] rdBin;
    logic [AW:0] rdGray;
    logic [AW:0] rdBinNext;
    logic [AW:0] wrGraySync1;
    logic [AW:0] wrGraySync2;
    logic [1:0]  rstSync;
    logic        rdRstN;
    logic        rdEmpty;
    logic        pop;

    //------------------------------------------------------------
    // Write side
    //------------------------------------------------------------
    assign wrBinNext = wrBin + 1'b1;

    always_ff @(posedge baseClk)
    begin
        if (!rstN)
        begin
            wrBin  <= '0;
            wrGray <= '0;
        end
        else if (pixelWe)
        begin
            wrBin  <= wrBinNext;
            wrGray <= wrBinNext ^ (wrBinNext >> 1);
        end
    end

    always_ff @(posedge baseClk)
    begin
        if (pixelWe)
            mem[wrBin[AW-1:0]] <= pixel;
    end

    // Read pointer into base clock
    always_ff @(posedge baseClk)
    begin
        if (!rstN)
        begin
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end
        else
        begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
        end
    end

    // Full when the top two Gray bits differ, rest equal
    assign full      = (wrGray == {~rdGraySync2[AW:AW-1], rdGraySync2[AW-2:0]});
    assign fifoEmpty = (wrGray == rdGraySync2);

    //------------------------------------------------------------
    // Read side
    //------------------------------------------------------------
    // Reset release aligned to pixelClk
    always_ff @(posedge pixelClk)
    begin
        rstSync <= {rstSync[0], rstN};
    end
    assign rdRstN = rstSync[1];

    always_ff @(posedge pixelClk)
    begin
        if (!rdRstN)
        begin
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
        end
        else
        begin
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
        end
    end

    assign rdEmpty   = (rdGray == wrGraySync2);
    assign pop       = vde && !rdEmpty;
    assign rdBinNext = rdBin + 1'b1;

    always_ff @(posedge pixelClk)
    begin
        if (!rdRstN)
        begin
            rdBin      <= '0;
            rdGray     <= '0;
            pixelValid <= 1'b0;
        end
        else
        begin
            pixelValid <= pop;
            if (pop)
            begin
                rdBin  <= rdBinNext;
                rdGray <= rdBinNext ^ (rdBinNext >> 1);
            end
        end
    end

    // Registered read port
    always_ff @(posedge pixelClk)
    begin
        if (pop)
            vRgb <= mem[rdBin[AW-1:0]];
    end

    // Generator honours back-pressure
    assert property (@(posedge baseClk) disable iff (!rstN) pixelWe |-> !full);

endmodule

`default_nettype wire

//--- hw/pixelPkg.sv
// Shared pixel, mode and register definitions for the base pixel path; referenced by scoped name
`default_nettype none

package pixelPkg;

    // One RGB pixel, red in the high byte
    typedef logic [23:0] rgbT;

    // Drawing mode register encoding
    typedef enum logic [1:0] {
        FILL     = 2'd0,
        BARS     = 2'd1,
        GRADIENT = 2'd2
    } drawModeT;

    // Generator sequencing states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        STOPPING
    } ctrlStateT;

    // Wishbone register map
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_MODE   = 2'd1;
    localparam logic [1:0] REG_COLOR  = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

    // Colour bars, left to right
    localparam rgbT BAR_COLORS [0:7] = '{
        24'hFFFFFF, 24'hFFFF00, 24'h00FFFF, 24'h00FF00,
        24'hFF00FF, 24'hFF0000, 24'h0000FF, 24'h000000
    };

endpackage

`default_nettype wire

//--- verification/baseChecker.sv
// Pixel-side checker of the base pixel path; predicts each valid pixel and keeps the test counts
`timescale 1ns/1ps
`default_nettype none

module baseChecker #(
    parameter int pHdisplay = 640,
    parameter int pVdisplay = 480
)(
    input logic          pixelClk,
    input pixelPkg::rgbT vRgb,
    input logic          pixelValid
);

    string              testName;
    pixelPkg::drawModeT mode;
    pixelPkg::rgbT      color;
    pixelPkg::rgbT      expPixel;
    bit                 active = 1'b0;
    int                 xPos;
    int                 yPos;
    int                 framePos;
    int                 pixCount;
    int                 testErrs;
    int                 errCount = 0;
    int                 passCount = 0;
    int                 failCount = 0;

    //------------------------------------------------------------
    // Reference pattern
    //------------------------------------------------------------
    function automatic pixelPkg::rgbT predictPixel(input int col, input int row, input int frm);
        case (mode)
            pixelPkg::FILL: return color;
            // Eight equal bands across the line
            pixelPkg::BARS: return pixelPkg::BAR_COLORS[(col * 8) / pHdisplay];
            default:        return {8'(col), 8'(row), 8'(frm)};
        endcase
    endfunction

    // Arm the model for a new test
    task automatic beginTest(input string name, input pixelPkg::drawModeT m,
                             input pixelPkg::rgbT c);
        testName = name;
        mode     = m;
        color    = c;
        xPos     = 0;
        yPos     = 0;
        framePos = 0;
        pixCount = 0;
        testErrs = 0;
        active   = 1'b1;
    endtask

    // Register readback comparison
    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
            testErrs++;
        end
    endtask

    // Pixel count over whole frames and one result line per test
    task automatic endTest(input int frames);
        if (pixCount != frames * pHdisplay * pVdisplay)
        begin
            $display("Test %s expected %0d pixels but received %0d", testName,
                     frames * pHdisplay * pVdisplay, pixCount);
            testErrs++;
        end
        if (testErrs == 0)
        begin
            $display("Test %s passed, %0d pixels", testName, pixCount);
            passCount++;
        end
        else
        begin
            $display("Test %s failed with %0d errors", testName, testErrs);
            failCount++;
        end
        errCount += testErrs;
        active = 1'b0;
    endtask

    //------------------------------------------------------------
    // Pixel monitor on the falling edge of pixelClk
    //------------------------------------------------------------
    always @(negedge pixelClk)
    begin
        if (pixelValid === 1'b1)
        begin
            if (!active)
            begin
                $display("Pixel %h arrived while no test was running", vRgb);
                errCount++;
            end
            else
            begin
                expPixel = predictPixel(xPos, yPos, framePos);
                if (vRgb !== expPixel)
                begin
                    $display("FAIL %s pixel %0d expected %h actual %h",
                             testName, pixCount, expPixel, vRgb);
                    testErrs++;
                end
                pixCount++;
                // Raster step
                if (xPos == pHdisplay - 1)
                begin
                    xPos = 0;
                    if (yPos == pVdisplay - 1)
                    begin
                        yPos = 0;
                        framePos++;
                    end
                    else
                        yPos++;
                end
                else
                    xPos++;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/baseTb.sv
// Testbench top of the base pixel path; clocks, reset, Wishbone cycles, vde and the test sequence
`timescale 1ns/1ps
`default_nettype none

module baseTb;

    localparam int hDisplay   = 16;
    localparam int vDisplay   = 8;
    localparam int frameSize  = hDisplay * vDisplay;
    localparam int busTimeout = 50;

    logic          baseClk;
    logic          pixelClk;
    logic          rstN;
    logic          wbCyc;
    logic          wbStb;
    logic          wbWe;
    logic [1:0]    wbAdr;
    logic [31:0]   wbDatWr;
    logic [31:0]   wbDatRd;
    logic          wbAck;
    logic          vde;
    pixelPkg::rgbT vRgb;
    logic          pixelValid;
    integer        seed;
    bit            vdeRandom;

    captiveShizuhaBase #(
        .pHdisplay (hDisplay), .pVdisplay (vDisplay), .pBuffDepth (16)
    ) u_captiveShizuhaBase (
        .baseClk (baseClk), .pixelClk (pixelClk), .rstN (rstN),
        .wbCyc (wbCyc), .wbStb (wbStb), .wbWe (wbWe), .wbAdr (wbAdr),
        .wbDatWr (wbDatWr), .wbDatRd (wbDatRd), .wbAck (wbAck),
        .vde (vde), .vRgb (vRgb), .pixelValid (pixelValid)
    );

    baseChecker #(
        .pHdisplay (hDisplay), .pVdisplay (vDisplay)
    ) u_baseChecker (
        .pixelClk (pixelClk), .vRgb (vRgb), .pixelValid (pixelValid)
    );

    //------------------------------------------------------------
    // Clocks and vde strobe
    //------------------------------------------------------------
    always #2 baseClk = ~baseClk;
    always #3 pixelClk = ~pixelClk;

    // Random gaps at half duty in back-pressure runs and high otherwise
    always @(posedge pixelClk)
    begin
        #1;
        vde = vdeRandom ? 1'($random(seed)) : 1'b1;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $finish;
    endtask

    // One classic cycle; address and data held through the ack cycle
    task automatic wbCycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge baseClk);
        #1;
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        wbWe    = we;
        wbAdr   = adr;
        wbDatWr = wdat;
        do
        begin
            @(posedge baseClk);
            #1;
            waited++;
        end while (!wbAck && waited < busTimeout);
        if (!wbAck)
            abortRun("Timeout waiting for wbAck");
        // Ack one cycle after the strobe and high for a single cycle
        u_baseChecker.compareValue("ack latency", 32'd1, 32'(waited));
        rdat = wbDatRd;
        @(posedge baseClk);
        #1;
        u_baseChecker.compareValue("ack width", 32'd0, 32'(wbAck));
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    // Poll status until not busy and FIFO drained
    task automatic waitIdle();
        logic [31:0] rdat;
        int          polls;
        polls = 0;
        do
        begin
            wbCycle(1'b0, pixelPkg::REG_STATUS, 32'd0, rdat);
            polls++;
        end while (rdat != 32'd2 && polls < 1000);
        if (rdat != 32'd2)
            abortRun("Timeout waiting for the generator to go idle");
    endtask

    // Wait until the checker has counted the target number of pixels
    task automatic waitPixels(input int target);
        int waited;
        waited = 0;
        while (u_baseChecker.pixCount < target && waited < 20 * frameSize)
        begin
            @(posedge pixelClk);
            waited++;
        end
        if (u_baseChecker.pixCount < target)
            abortRun("Timeout waiting for pixels from the FIFO");
    endtask

    //------------------------------------------------------------
    // One run of whole frames
    //------------------------------------------------------------
    task automatic runFrames(input string name, input pixelPkg::drawModeT mode,
                             input pixelPkg::rgbT color, input int frames,
                             input bit randomVde, input bit busyModeWrite);
        logic [31:0] rdat;
        vdeRandom = randomVde;
        u_baseChecker.beginTest(name, mode, color);
        wbCycle(1'b1, pixelPkg::REG_COLOR, 32'(color), rdat);
        wbCycle(1'b1, pixelPkg::REG_MODE, 32'(mode), rdat);
        wbCycle(1'b1, pixelPkg::REG_CTRL, 32'd1, rdat);
        // Mode change while busy must be dropped
        if (busyModeWrite)
        begin
            wbCycle(1'b1, pixelPkg::REG_MODE, 32'(pixelPkg::FILL), rdat);
            wbCycle(1'b0, pixelPkg::REG_MODE, 32'd0, rdat);
            u_baseChecker.compareValue("mode while busy", 32'(mode), rdat);
        end
        // Disable inside the last frame so it still completes
        waitPixels((frames - 1) * frameSize + 1);
        wbCycle(1'b1, pixelPkg::REG_CTRL, 32'd0, rdat);
        waitIdle();
        waitPixels(frames * frameSize);
        u_baseChecker.endTest(frames);
        vdeRandom = 1'b0;
    endtask

    initial
    begin
        logic [31:0]   rdat;
        pixelPkg::rgbT color;
        int            first;
        seed      = 94304;
        baseClk   = 1'b0;
        pixelClk  = 1'b0;
        rstN      = 1'b0;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = 2'd0;
        wbDatWr   = 32'd0;
        vde       = 1'b1;
        vdeRandom = 1'b0;
        repeat (10) @(posedge baseClk);
        #1;
        rstN = 1'b1;
        repeat (4) @(posedge pixelClk);

        // Reset values and idle register writes
        u_baseChecker.beginTest("regReset", pixelPkg::FILL, 24'd0);
        wbCycle(1'b0, pixelPkg::REG_CTRL, 32'd0, rdat);
        u_baseChecker.compareValue("ctrl", 32'd0, rdat);
        wbCycle(1'b0, pixelPkg::REG_MODE, 32'd0, rdat);
        u_baseChecker.compareValue("mode", 32'(pixelPkg::FILL), rdat);
        wbCycle(1'b0, pixelPkg::REG_COLOR, 32'd0, rdat);
        u_baseChecker.compareValue("color", 32'd0, rdat);
        wbCycle(1'b0, pixelPkg::REG_STATUS, 32'd0, rdat);
        u_baseChecker.compareValue("status", 32'd2, rdat);
        wbCycle(1'b1, pixelPkg::REG_MODE, 32'(pixelPkg::BARS), rdat);
        wbCycle(1'b0, pixelPkg::REG_MODE, 32'd0, rdat);
        u_baseChecker.compareValue("mode write", 32'(pixelPkg::BARS), rdat);
        color = 24'($random(seed));
        wbCycle(1'b1, pixelPkg::REG_COLOR, 32'(color), rdat);
        wbCycle(1'b0, pixelPkg::REG_COLOR, 32'd0, rdat);
        u_baseChecker.compareValue("color write", 32'(color), rdat);
        u_baseChecker.endTest(0);

        // Pattern tests in a seeded rotation
        first = $unsigned($random(seed)) % 3;
        for (int k = 0; k < 3; k++)
        begin
            color = 24'($random(seed));
            case ((first + k) % 3)
                0:       runFrames("fill", pixelPkg::FILL, color, 2, 1'b0, 1'b0);
                1:       runFrames("bars", pixelPkg::BARS, color, 2, 1'b0, 1'b0);
                default: runFrames("gradient", pixelPkg::GRADIENT, color, 3, 1'b0, 1'b0);
            endcase
        end
        runFrames("backPressure", pixelPkg::GRADIENT, 24'd0, 2, 1'b1, 1'b1);

        // vde high with nothing queued
        u_baseChecker.beginTest("idle", pixelPkg::FILL, 24'd0);
        repeat (100) @(posedge pixelClk);
        u_baseChecker.endTest(0);

        $display("Tests passed %0d, failed %0d, errors %0d", u_baseChecker.passCount,
                 u_baseChecker.failCount, u_baseChecker.errCount);
        if (u_baseChecker.errCount == 0 && u_baseChecker.failCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
